/* src/periph_pkg.sv */
`default_nettype none

package periph_pkg;

	typedef logic [31:0] word_t;   // Bus data word, also timer counts and tops
	typedef logic [4:0]  addr_t;   // Register word address
	typedef logic [16:0] presc_t;
	typedef logic [7:0]  port_t;   // GPIO port or byte-wide register
	typedef logic [2:0]  irq_vec_t;

	typedef enum logic [1:0] {
		IRQ_MASKED  = 2'd0,
		IRQ_ENABLED = 2'd1,
		IRQ_SERVING = 2'd2
	} irq_state_t;

	// Register map
	localparam addr_t ADDR_TIMER0    = 5'd0;
	localparam addr_t ADDR_TIMER1    = 5'd1;
	localparam addr_t ADDR_TOP0      = 5'd2;
	localparam addr_t ADDR_TOP1      = 5'd3;
	localparam addr_t ADDR_PRESC0    = 5'd4;
	localparam addr_t ADDR_PRESC1    = 5'd5;
	localparam addr_t ADDR_GPIO_DIR  = 5'd11;
	localparam addr_t ADDR_GPIO_DAT  = 5'd12;
	localparam addr_t ADDR_GPIO_IN   = 5'd13;
	localparam addr_t ADDR_ALT_FUNCT = 5'd14;
	localparam addr_t ADDR_IRQ_CTL   = 5'd15;
	localparam addr_t ADDR_ID0       = 5'd18;
	localparam addr_t ADDR_ID1       = 5'd19;
	localparam addr_t ADDR_PWM       = 5'd20;

	localparam word_t ID0_WORD = {8'h72, 8'h69, 8'h68, 8'h43};  // "Chir", first byte lowest
	localparam word_t ID1_WORD = {16'h0000, 8'h21, 8'h70};
	localparam word_t READ_UNMAPPED = 32'hFFFF_FFFF;

	localparam presc_t PRESC_RESET    = 17'd100;
	localparam port_t  GPIO_DAT_RESET = 8'h55;
	localparam port_t  PWM_RESET      = 8'd66;

	// Bit positions in the alternate-function register
	localparam int ALT_T1_TOGGLE = 0;
	localparam int ALT_EDGE_IRQ  = 1;
	localparam int ALT_T0_IRQ    = 2;
	localparam int ALT_FORCE_LOW = 3;
	localparam int ALT_PWM_OUT   = 5;

endpackage

`default_nettype wire

/* src/periph_timer.sv */
`timescale 1ns/100ps
`default_nettype none

module periph_timer #(
	parameter int TIMER_W = 32,
	parameter int PRESC_W = 17
) (
	input  wire                  clk,
	input  wire                  rst,
	input  wire                  wr_count_i,
	input  wire                  wr_top_i,
	input  wire                  wr_presc_i,
	input  wire periph_pkg::word_t wdata_i,
	output periph_pkg::word_t    count_o,
	output periph_pkg::word_t    top_o,
	output periph_pkg::presc_t   presc_o,
	output logic                 wrap_o
);

	logic [TIMER_W-1:0] count_q;
	logic [TIMER_W-1:0] top_q;
	logic [PRESC_W-1:0] presc_q;
	logic [PRESC_W-1:0] pre_cnt_q;
	logic               step;

	// The count moves only on the cycle where the pre-counter hits the prescaler
	assign step = pre_cnt_q == presc_q;

	// Combinational so that listeners see the wrap at the same edge the count clears
	assign wrap_o = step && (count_q == top_q);

	assign count_o = periph_pkg::word_t'(count_q);
	assign top_o   = periph_pkg::word_t'(top_q);
	assign presc_o = periph_pkg::presc_t'(presc_q);

	always_ff @(posedge clk) begin
		if (rst) begin
			pre_cnt_q <= '0;
		end else if (step) begin
			pre_cnt_q <= '0;
		end else begin
			pre_cnt_q <= pre_cnt_q + 1'b1;  // Not cleared by register writes
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			count_q <= '0;
		end else if (wr_count_i) begin
			count_q <= TIMER_W'(wdata_i);
		end else if (wrap_o) begin
			count_q <= '0;
		end else if (step) begin
			count_q <= count_q + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			top_q   <= '1;
			presc_q <= PRESC_W'(periph_pkg::PRESC_RESET);
		end else begin
			if (wr_top_i)
				top_q <= TIMER_W'(wdata_i);
			if (wr_presc_i)
				presc_q <= PRESC_W'(wdata_i);
		end
	end

endmodule

`default_nettype wire

/* src/pwm_gen.sv */
`timescale 1ns/100ps
`default_nettype none

module pwm_gen (
	input  wire                    clk,
	input  wire                    rst,
	input  wire                    wr_setting_i,
	input  wire periph_pkg::port_t wdata_i,
	output periph_pkg::port_t      setting_o,
	output logic                   pwm_o
);

	periph_pkg::port_t cnt_q;
	periph_pkg::port_t cnt_next;

	assign cnt_next = cnt_q + 1'b1;

	always_ff @(posedge clk) begin
		if (rst) begin
			cnt_q     <= '0;
			setting_o <= periph_pkg::PWM_RESET;
			pwm_o     <= 1'b0;
		end else begin
			cnt_q <= cnt_next;
			if (cnt_next == '0)
				pwm_o <= 1'b0;
			// Checked second, so a setting of 0 keeps the output high all period
			if (cnt_next >= setting_o)
				pwm_o <= 1'b1;
			if (wr_setting_i)
				setting_o <= wdata_i;
		end
	end

endmodule

`default_nettype wire

/* src/irq_ctrl.sv */
`timescale 1ns/100ps
`default_nettype none

module irq_ctrl (
	input  wire                    clk,
	input  wire                    rst,
	input  wire                    ctl_wr_i,
	input  wire periph_pkg::word_t wdata_i,
	input  wire                    edge_pin_i,
	input  wire                    t0_wrap_i,
	input  wire periph_pkg::port_t alt_i,
	input  wire                    irq_ack_i,
	input  wire                    irq_return_i,
	output logic                   irq_o,
	output periph_pkg::irq_vec_t   irq_vec_o
);

	// Control register bits
	localparam int CTL_CLR_INT0 = 0;
	localparam int CTL_CLR_INT1 = 1;
	localparam int CTL_SET_INT2 = 2;
	localparam int CTL_ENABLE   = 3;
	localparam int CTL_UPD_EN   = 4;
	localparam int CTL_CLR_INT2 = 5;

	logic int0_q;
	logic int1_q;
	logic int2_q;
	logic edge_q;

	periph_pkg::irq_state_t state_q;
	periph_pkg::irq_state_t state_d;

	assign irq_o = (int0_q || int1_q || int2_q) && (state_q == periph_pkg::IRQ_ENABLED);

	// Timer source outranks the software source, edge pin is the fallback
	assign irq_vec_o = int1_q ? 3'd2 : (int2_q ? 3'd3 : 3'd1);

	always_comb begin
		state_d = state_q;
		case (state_q)
			periph_pkg::IRQ_ENABLED:
				if (irq_ack_i)
					state_d = periph_pkg::IRQ_SERVING;
			periph_pkg::IRQ_SERVING:
				if (irq_return_i)
					state_d = periph_pkg::IRQ_ENABLED;
			default: ;
		endcase
		if (ctl_wr_i && wdata_i[CTL_UPD_EN])
			state_d = wdata_i[CTL_ENABLE] ? periph_pkg::IRQ_ENABLED : periph_pkg::IRQ_MASKED;
	end

	always_ff @(posedge clk) begin
		if (rst)
			state_q <= periph_pkg::IRQ_MASKED;
		else
			state_q <= state_d;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			int0_q <= 1'b0;
			int1_q <= 1'b0;
			int2_q <= 1'b0;
			edge_q <= 1'b0;
		end else begin
			if (alt_i[periph_pkg::ALT_EDGE_IRQ]) begin
				if (edge_pin_i && !edge_q)
					int0_q <= 1'b1;
				edge_q <= edge_pin_i;
			end else begin
				edge_q <= 1'b0;  // A pin already high counts as an edge once enabled
			end
			if (alt_i[periph_pkg::ALT_T0_IRQ] && t0_wrap_i)
				int1_q <= 1'b1;
			// Software writes come last and override the sources
			if (ctl_wr_i) begin
				if (wdata_i[CTL_CLR_INT0])
					int0_q <= 1'b0;
				if (wdata_i[CTL_CLR_INT1])
					int1_q <= 1'b0;
				int2_q <= wdata_i[CTL_SET_INT2] && !wdata_i[CTL_CLR_INT2];
			end
		end
	end

endmodule

`default_nettype wire

/* src/periph_regs.sv */
`timescale 1ns/100ps
`default_nettype none

module periph_regs (
	input  wire                     clk,
	input  wire                     rst,
	input  wire periph_pkg::addr_t  addr_i,
	input  wire periph_pkg::word_t  wdata_i,
	input  wire                     wen_i,
	output periph_pkg::word_t       rdata_o,
	input  wire periph_pkg::port_t  gpio_in_i,
	output periph_pkg::port_t       gpio_out_o,
	output periph_pkg::port_t       gpio_oeb_o,
	input  wire periph_pkg::word_t  count0_i,
	input  wire periph_pkg::word_t  top0_i,
	input  wire periph_pkg::presc_t presc0_i,
	input  wire periph_pkg::word_t  count1_i,
	input  wire periph_pkg::word_t  top1_i,
	input  wire periph_pkg::presc_t presc1_i,
	input  wire periph_pkg::port_t  pwm_setting_i,
	input  wire                     t1_wrap_i,
	input  wire                     pwm_i,
	output periph_pkg::port_t       alt_o,
	output logic                    wr_count0_o,
	output logic                    wr_top0_o,
	output logic                    wr_presc0_o,
	output logic                    wr_count1_o,
	output logic                    wr_top1_o,
	output logic                    wr_presc1_o,
	output logic                    wr_pwm_o,
	output logic                    ctl_wr_o
);

	periph_pkg::port_t dir_q;
	periph_pkg::port_t dat_q;
	periph_pkg::port_t alt_q;
	logic              wr_dir;
	logic              wr_dat;
	logic              wr_alt;

	// One decode per address, the blocks behind it only see strobes
	assign wr_count0_o = wen_i && (addr_i == periph_pkg::ADDR_TIMER0);
	assign wr_count1_o = wen_i && (addr_i == periph_pkg::ADDR_TIMER1);
	assign wr_top0_o   = wen_i && (addr_i == periph_pkg::ADDR_TOP0);
	assign wr_top1_o   = wen_i && (addr_i == periph_pkg::ADDR_TOP1);
	assign wr_presc0_o = wen_i && (addr_i == periph_pkg::ADDR_PRESC0);
	assign wr_presc1_o = wen_i && (addr_i == periph_pkg::ADDR_PRESC1);
	assign wr_pwm_o    = wen_i && (addr_i == periph_pkg::ADDR_PWM);
	assign ctl_wr_o    = wen_i && (addr_i == periph_pkg::ADDR_IRQ_CTL);
	assign wr_dir      = wen_i && (addr_i == periph_pkg::ADDR_GPIO_DIR);
	assign wr_dat      = wen_i && (addr_i == periph_pkg::ADDR_GPIO_DAT);
	assign wr_alt      = wen_i && (addr_i == periph_pkg::ADDR_ALT_FUNCT);

	assign gpio_out_o = dat_q;
	assign gpio_oeb_o = ~dir_q;  // A direction bit of 1 drives the pin
	assign alt_o      = alt_q;

	always_ff @(posedge clk) begin
		if (rst) begin
			dir_q <= '0;
			alt_q <= '0;
		end else begin
			if (wr_dir)
				dir_q <= periph_pkg::port_t'(wdata_i);
			if (wr_alt)
				alt_q <= periph_pkg::port_t'(wdata_i);
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			dat_q <= periph_pkg::GPIO_DAT_RESET;
		end else begin
			if (alt_q[periph_pkg::ALT_T1_TOGGLE] && t1_wrap_i)
				dat_q[0] <= ~dat_q[0];
			if (alt_q[periph_pkg::ALT_FORCE_LOW])
				dat_q[0] <= 1'b0;  // Later assignment, so it beats the toggle
			if (alt_q[periph_pkg::ALT_PWM_OUT])
				dat_q[1] <= pwm_i;
			// A bus write to the data register takes the whole byte
			if (wr_dat)
				dat_q <= periph_pkg::port_t'(wdata_i);
		end
	end

	always_comb begin
		case (addr_i)
			periph_pkg::ADDR_TIMER0:
				rdata_o = count0_i;
			periph_pkg::ADDR_TIMER1:
				rdata_o = count1_i;
			periph_pkg::ADDR_TOP0:
				rdata_o = top0_i;
			periph_pkg::ADDR_TOP1:
				rdata_o = top1_i;
			periph_pkg::ADDR_PRESC0:
				rdata_o = periph_pkg::word_t'(presc0_i);
			periph_pkg::ADDR_PRESC1:
				rdata_o = periph_pkg::word_t'(presc1_i);
			periph_pkg::ADDR_GPIO_DIR:
				rdata_o = periph_pkg::word_t'(dir_q);
			periph_pkg::ADDR_GPIO_DAT:
				rdata_o = periph_pkg::word_t'(dat_q);
			periph_pkg::ADDR_GPIO_IN:
				rdata_o = periph_pkg::word_t'(gpio_in_i);
			periph_pkg::ADDR_ALT_FUNCT:
				rdata_o = periph_pkg::word_t'(alt_q);
			periph_pkg::ADDR_ID0:
				rdata_o = periph_pkg::ID0_WORD;
			periph_pkg::ADDR_ID1:
				rdata_o = periph_pkg::ID1_WORD;
			periph_pkg::ADDR_PWM:
				rdata_o = periph_pkg::word_t'(pwm_setting_i);
			default:
				rdata_o = periph_pkg::READ_UNMAPPED;  // Includes the write-only control register
		endcase
	end

endmodule

`default_nettype wire

/* src/periph_top.sv */
`timescale 1ns/100ps
`default_nettype none

module periph_top #(
	parameter int TIMER_W = 32,
	parameter int PRESC_W = 17
) (
	input  wire                    clk,
	input  wire                    rst,
	input  wire periph_pkg::addr_t addr_i,
	input  wire periph_pkg::word_t wdata_i,
	input  wire                    wen_i,
	output periph_pkg::word_t      rdata_o,
	input  wire periph_pkg::port_t gpio_in_i,
	output periph_pkg::port_t      gpio_out_o,
	output periph_pkg::port_t      gpio_oeb_o,
	input  wire                    irq_ack_i,
	input  wire                    irq_return_i,
	output logic                   irq_o,
	output periph_pkg::irq_vec_t   irq_vec_o
);

	periph_pkg::word_t  count0;
	periph_pkg::word_t  top0;
	periph_pkg::presc_t presc0;
	periph_pkg::word_t  count1;
	periph_pkg::word_t  top1;
	periph_pkg::presc_t presc1;
	periph_pkg::port_t  pwm_setting;
	periph_pkg::port_t  alt;
	logic               t0_wrap;
	logic               t1_wrap;
	logic               pwm;
	logic               wr_count0;
	logic               wr_top0;
	logic               wr_presc0;
	logic               wr_count1;
	logic               wr_top1;
	logic               wr_presc1;
	logic               wr_pwm;
	logic               ctl_wr;

	periph_regs i_regs (
		.clk           (clk),
		.rst           (rst),
		.addr_i        (addr_i),
		.wdata_i       (wdata_i),
		.wen_i         (wen_i),
		.rdata_o       (rdata_o),
		.gpio_in_i     (gpio_in_i),
		.gpio_out_o    (gpio_out_o),
		.gpio_oeb_o    (gpio_oeb_o),
		.count0_i      (count0),
		.top0_i        (top0),
		.presc0_i      (presc0),
		.count1_i      (count1),
		.top1_i        (top1),
		.presc1_i      (presc1),
		.pwm_setting_i (pwm_setting),
		.t1_wrap_i     (t1_wrap),
		.pwm_i         (pwm),
		.alt_o         (alt),
		.wr_count0_o   (wr_count0),
		.wr_top0_o     (wr_top0),
		.wr_presc0_o   (wr_presc0),
		.wr_count1_o   (wr_count1),
		.wr_top1_o     (wr_top1),
		.wr_presc1_o   (wr_presc1),
		.wr_pwm_o      (wr_pwm),
		.ctl_wr_o      (ctl_wr)
	);

	periph_timer #(
		.TIMER_W (TIMER_W),
		.PRESC_W (PRESC_W)
	) i_timer0 (
		.clk        (clk),
		.rst        (rst),
		.wr_count_i (wr_count0),
		.wr_top_i   (wr_top0),
		.wr_presc_i (wr_presc0),
		.wdata_i    (wdata_i),
		.count_o    (count0),
		.top_o      (top0),
		.presc_o    (presc0),
		.wrap_o     (t0_wrap)
	);

	periph_timer #(
		.TIMER_W (TIMER_W),
		.PRESC_W (PRESC_W)
	) i_timer1 (
		.clk        (clk),
		.rst        (rst),
		.wr_count_i (wr_count1),
		.wr_top_i   (wr_top1),
		.wr_presc_i (wr_presc1),
		.wdata_i    (wdata_i),
		.count_o    (count1),
		.top_o      (top1),
		.presc_o    (presc1),
		.wrap_o     (t1_wrap)
	);

	pwm_gen i_pwm (
		.clk          (clk),
		.rst          (rst),
		.wr_setting_i (wr_pwm),
		.wdata_i      (wdata_i[7:0]),
		.setting_o    (pwm_setting),
		.pwm_o        (pwm)
	);

	irq_ctrl i_irq (
		.clk          (clk),
		.rst          (rst),
		.ctl_wr_i     (ctl_wr),
		.wdata_i      (wdata_i),
		.edge_pin_i   (gpio_in_i[1]),  // Edge interrupt pin
		.t0_wrap_i    (t0_wrap),
		.alt_i        (alt),
		.irq_ack_i    (irq_ack_i),
		.irq_return_i (irq_return_i),
		.irq_o        (irq_o),
		.irq_vec_o    (irq_vec_o)
	);

endmodule

`default_nettype wire

/* bench/periph_props.sv */
`timescale 1ns/100ps
`default_nettype none

module periph_props (
	input wire                    clk,
	input wire                    rst,
	input wire periph_pkg::word_t count_i,
	input wire periph_pkg::word_t top_i,
	input wire                    count_wr_i,
	input wire                    irq_enabled_i,
	input wire                    irq_ack_i,
	input wire                    ctl_wr_i
);

	// A write to count or top may leave count above top for one cycle
	count_in_range: assert property (@(posedge clk) disable iff (rst)
		!$past(count_wr_i) |-> count_i <= top_i)
		else $error("Timer count 0x%08h above top 0x%08h", count_i, top_i);

	// Only an acknowledge or a control write takes the controller out of the enabled state
	enabled_holds: assert property (@(posedge clk) disable iff (rst)
		irq_enabled_i && !irq_ack_i && !ctl_wr_i |=> irq_enabled_i)
		else $error("Interrupt controller left the enabled state on its own");

endmodule

// Each binding drives one of the two checks, the other one sees constants
bind periph_timer periph_props i_props (
	.clk           (clk),
	.rst           (rst),
	.count_i       (count_o),
	.top_i         (top_o),
	.count_wr_i    (wr_count_i || wr_top_i),
	.irq_enabled_i (1'b0),
	.irq_ack_i     (1'b0),
	.ctl_wr_i      (1'b0)
);

bind irq_ctrl periph_props i_props (
	.clk           (clk),
	.rst           (rst),
	.count_i       (32'd0),
	.top_i         (32'd0),
	.count_wr_i    (1'b0),
	.irq_enabled_i (state_q == periph_pkg::IRQ_ENABLED),
	.irq_ack_i     (irq_ack_i),
	.ctl_wr_i      (ctl_wr_i)
);

`default_nettype wire

/* bench/periph_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module periph_tb;

	localparam int CLK_PERIOD = 20;
	localparam int SAMPLE_DLY = CLK_PERIOD / 4;
	localparam int MAX_CYCLES = 6000;  // The sequence needs about 1200 cycles

	logic                 clk;
	logic                 rst;
	periph_pkg::addr_t    addr;
	periph_pkg::word_t    wdata;
	logic                 wen;
	periph_pkg::word_t    rdata;
	periph_pkg::port_t    gpio_in;
	periph_pkg::port_t    gpio_out;
	periph_pkg::port_t    gpio_oeb;
	logic                 irq_ack;
	logic                 irq_return;
	logic                 irq;
	periph_pkg::irq_vec_t irq_vec;
	logic [31:0]          lcg_state;
	int                   cycles = 0;

	periph_top i_dut (
		.clk          (clk),
		.rst          (rst),
		.addr_i       (addr),
		.wdata_i      (wdata),
		.wen_i        (wen),
		.rdata_o      (rdata),
		.gpio_in_i    (gpio_in),
		.gpio_out_o   (gpio_out),
		.gpio_oeb_o   (gpio_oeb),
		.irq_ack_i    (irq_ack),
		.irq_return_i (irq_return),
		.irq_o        (irq),
		.irq_vec_o    (irq_vec)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("Timeout: the test did not finish within %0d cycles", MAX_CYCLES);
			$display("STATUS: FAIL");
			$fatal(1, "Run aborted by the cycle limit");
		end
	end

	task automatic report_fail(input string msg);
		$display("Fail at time %0t: %s", $time, msg);
		$display("STATUS: FAIL");
		$fatal(1, "Stopped at the first error");
	endtask

	function automatic periph_pkg::word_t next_random();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state;
	endfunction

	task automatic check_eq(input string what, input periph_pkg::word_t got,
			input periph_pkg::word_t exp);
		assert (got === exp)
			else report_fail($sformatf("%s is 0x%08h, expected 0x%08h", what, got, exp));
	endtask

	// Every bus task starts and ends right after a falling edge
	task automatic bus_write(input periph_pkg::addr_t a, input periph_pkg::word_t d);
		addr = a;
		wdata = d;
		wen = 1'b1;
		@(negedge clk);
		wen = 1'b0;
	endtask

	task automatic bus_read(input periph_pkg::addr_t a, output periph_pkg::word_t d);
		addr = a;
		#(SAMPLE_DLY);
		d = rdata;
		@(negedge clk);
	endtask

	task automatic read_check(input string what, input periph_pkg::addr_t a,
			input periph_pkg::word_t exp);
		periph_pkg::word_t d;
		bus_read(a, d);
		check_eq(what, d, exp);
	endtask

	task automatic idle(input int n);
		repeat (n) @(negedge clk);
	endtask

	task automatic wait_irq(input logic level, input int limit);
		int n;
		n = 0;
		while (irq !== level && n < limit) begin
			@(negedge clk);
			n++;
		end
		assert (irq === level)
			else report_fail($sformatf("irq_o did not go to %0b within %0d cycles", level, limit));
	endtask

	task automatic pulse(ref logic sig);
		sig = 1'b1;
		@(negedge clk);
		sig = 1'b0;
	endtask

	// The new prescaler lands on a step edge of the old one, so the pre-counter restarts at 0
	task automatic set_timer(input int idx, input periph_pkg::word_t presc,
			input periph_pkg::word_t top);
		periph_pkg::addr_t cnt_addr;
		periph_pkg::word_t old_presc;
		periph_pkg::word_t prev;
		periph_pkg::word_t cur;
		int n;
		cnt_addr = (idx == 0) ? periph_pkg::ADDR_TIMER0 : periph_pkg::ADDR_TIMER1;
		bus_write((idx == 0) ? periph_pkg::ADDR_TOP0 : periph_pkg::ADDR_TOP1, top);
		bus_write(cnt_addr, '0);  // Right after the top write, count never sits above top
		bus_read((idx == 0) ? periph_pkg::ADDR_PRESC0 : periph_pkg::ADDR_PRESC1, old_presc);
		bus_read(cnt_addr, prev);
		n = 0;
		do begin
			bus_read(cnt_addr, cur);
			n++;
		end while (cur == prev && n < int'(old_presc) + 2);
		assert (cur != prev) else report_fail("timer count did not advance");
		if (old_presc > 0)
			idle(int'(old_presc) - 1);
		bus_write((idx == 0) ? periph_pkg::ADDR_PRESC0 : periph_pkg::ADDR_PRESC1, presc);
	endtask

	assert property (@(posedge clk) $fell(rst) |-> !irq && gpio_oeb == 8'hFF && gpio_out == 8'h55)
		else report_fail("outputs wrong in the first cycle after reset");

	// An acknowledge moves the controller to serving, so the request drops at the next edge
	assert property (@(posedge clk) disable iff (rst)
		irq && irq_ack && !(wen && addr == periph_pkg::ADDR_IRQ_CTL) |=> !irq)
		else report_fail("irq_o still high after irq_ack_i");

	initial begin
		periph_pkg::word_t d;
		periph_pkg::word_t prev;
		periph_pkg::word_t top0;
		periph_pkg::word_t top1;
		periph_pkg::word_t dir;
		periph_pkg::word_t dat;
		periph_pkg::word_t setting;
		int highs;
		int last;
		int changes;
		logic prev_bit;
		clk = 1'b0;
		rst = 1'b1;
		addr = '0;
		wdata = '0;
		wen = 1'b0;
		gpio_in = '0;
		irq_ack = 1'b0;
		irq_return = 1'b0;
		lcg_state = 32'd94;
		idle(5);
		rst = 1'b0;

		check_eq("gpio_out_o after reset", periph_pkg::word_t'(gpio_out), 32'h55);
		check_eq("gpio_oeb_o after reset", periph_pkg::word_t'(gpio_oeb), 32'hFF);
		assert (!irq) else report_fail("irq_o high after reset");
		read_check("prescaler 0", periph_pkg::ADDR_PRESC0, 32'd100);
		read_check("prescaler 1", periph_pkg::ADDR_PRESC1, 32'd100);
		read_check("top 0", periph_pkg::ADDR_TOP0, 32'hFFFF_FFFF);
		read_check("top 1", periph_pkg::ADDR_TOP1, 32'hFFFF_FFFF);
		read_check("ID word 0", periph_pkg::ADDR_ID0, 32'h7269_6843);  // "Chir" from the low byte up
		read_check("ID word 1", periph_pkg::ADDR_ID1, 32'h0000_2170);
		read_check("unmapped address 7", 5'd7, 32'hFFFF_FFFF);

		top0 = next_random();
		top1 = next_random();
		dir = next_random();
		dat = next_random();
		setting = next_random();
		bus_write(periph_pkg::ADDR_TOP0, top0);
		bus_write(periph_pkg::ADDR_TIMER0, '0);
		bus_write(periph_pkg::ADDR_TOP1, top1);
		bus_write(periph_pkg::ADDR_TIMER1, '0);
		bus_write(periph_pkg::ADDR_GPIO_DIR, dir);
		bus_write(periph_pkg::ADDR_GPIO_DAT, dat);
		bus_write(periph_pkg::ADDR_PWM, setting);
		read_check("top 0 readback", periph_pkg::ADDR_TOP0, top0);
		read_check("top 1 readback", periph_pkg::ADDR_TOP1, top1);
		read_check("direction readback", periph_pkg::ADDR_GPIO_DIR, {24'h0, dir[7:0]});
		read_check("data readback", periph_pkg::ADDR_GPIO_DAT, {24'h0, dat[7:0]});
		read_check("PWM setting readback", periph_pkg::ADDR_PWM, {24'h0, setting[7:0]});
		check_eq("gpio_oeb_o", periph_pkg::word_t'(gpio_oeb), {24'h0, ~dir[7:0]});
		check_eq("gpio_out_o", periph_pkg::word_t'(gpio_out), {24'h0, dat[7:0]});

		set_timer(0, 32'd3, 32'd5);
		bus_read(periph_pkg::ADDR_TIMER0, prev);
		assert (prev <= 32'd5) else report_fail($sformatf("timer0 read %0d above top 5", prev));
		repeat (20) begin
			idle(3);
			bus_read(periph_pkg::ADDR_TIMER0, d);
			check_eq("timer0 count", d, (prev == 32'd5) ? 32'd0 : prev + 32'd1);
			prev = d;
		end

		bus_write(periph_pkg::ADDR_IRQ_CTL, 32'h18);  // Update the enable bit and set it
		bus_write(periph_pkg::ADDR_ALT_FUNCT, 32'h02);
		assert (!irq) else report_fail("irq_o high with no flag set");
		gpio_in[1] = 1'b1;
		wait_irq(1'b1, 4);
		check_eq("irq_vec_o for the edge pin", periph_pkg::word_t'(irq_vec), 32'd1);
		pulse(irq_ack);
		wait_irq(1'b0, 4);
		pulse(irq_return);
		wait_irq(1'b1, 4);
		bus_write(periph_pkg::ADDR_IRQ_CTL, 32'h01);
		wait_irq(1'b0, 4);
		bus_write(periph_pkg::ADDR_ALT_FUNCT, 32'h06);
		wait_irq(1'b1, 2 * 4 * 6);  // Two timer0 periods at prescaler 3 and top 5
		check_eq("irq_vec_o for the timer", periph_pkg::word_t'(irq_vec), 32'd2);
		bus_write(periph_pkg::ADDR_IRQ_CTL, 32'h13);
		bus_write(periph_pkg::ADDR_ALT_FUNCT, '0);
		gpio_in[1] = 1'b0;

		setting = next_random() >> 24;
		bus_write(periph_pkg::ADDR_PWM, setting);
		bus_write(periph_pkg::ADDR_ALT_FUNCT, 32'h20);
		idle(260);
		highs = 0;
		repeat (256) begin
			if (gpio_out[1])
				highs++;
			@(negedge clk);
		end
		check_eq("PWM high cycles in 256", periph_pkg::word_t'(highs), 32'd256 - setting);

		// Timer1 wraps every 4 cycles, so the toggle keeps trying to raise bit 0
		set_timer(1, 32'd0, 32'd3);
		bus_write(periph_pkg::ADDR_GPIO_DAT, 32'h01);
		bus_write(periph_pkg::ADDR_ALT_FUNCT, 32'h09);  // Force low on top of the toggle
		repeat (16) begin
			idle(1);
			assert (!gpio_out[0]) else report_fail("gpio_out_o bit 0 not held low");
		end

		bus_write(periph_pkg::ADDR_ALT_FUNCT, 32'h01);
		last = -1;
		changes = 0;
		prev_bit = gpio_out[0];
		for (int i = 1; i <= 24; i++) begin
			@(negedge clk);
			if (gpio_out[0] != prev_bit) begin
				if (last >= 0)
					assert (i - last == 4)
						else report_fail($sformatf("bit 0 toggled after %0d cycles", i - last));
				last = i;
				changes++;
			end
			prev_bit = gpio_out[0];
		end
		assert (changes >= 5) else report_fail("gpio_out_o bit 0 did not toggle on timer1 wraps");

		$display("STATUS: PASS");
		$finish;
	end

endmodule

`default_nettype wire

/* sources.f */
src/periph_pkg.sv
src/periph_timer.sv
src/pwm_gen.sv
src/irq_ctrl.sv
src/periph_regs.sv
src/periph_top.sv
bench/periph_props.sv
bench/periph_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= periph_tb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

SOURCES := $(shell cat $(FILELIST))
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "STATUS: FAIL" $(LOG); then \
		echo "Simulation reported a failure"; exit 1; \
	fi
	@if ! grep -q "STATUS: PASS" $(LOG); then \
		echo "Simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
